/* Makefile */
# Verilator build and run for the GPU load/store memory path.

VERILATOR  ?= verilator
TOP        ?= gpu_mem_tb
FILELIST   ?= files.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
JOBS       ?= 0
VFLAGS     ?= --binary --assert -Wno-fatal -j $(JOBS)
LINT_FLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -Mdir $(BUILD_DIR) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q '^TB PASSED$$' $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/gpu_mem_tb.sv */
`timescale 1ns/100ps

module gpu_mem_tb;

  import gpu_mem_pkg::*;

  localparam int req_depth  = 4;
  localparam int resp_depth = 4;
  localparam int mem_words  = 256;
  localparam int idx_w      = $clog2(mem_words);
  localparam int addr_span  = 64;   // Words touched by the random traffic.

  logic              clk;
  logic              rst;
  logic              req_valid;
  logic              req_write;
  logic [tag_w-1:0]  req_tag;
  logic [addr_w-1:0] req_addr;
  logic [data_w-1:0] req_wdata;
  logic              req_credit;
  logic              resp_valid;
  logic [tag_w-1:0]  resp_tag;
  logic [data_w-1:0] resp_rdata;
  logic              resp_ready;

  logic              ready_level;   // Level that resp_ready takes at the next falling edge.
  logic [data_w-1:0] ref_mem [mem_words];
  logic [tag_w-1:0]  exp_tag [$];
  logic [data_w-1:0] exp_data [$];
  int                credits;
  int                credits_returned;
  int                sent;
  int                errors;
  int                test_errors;
  int                tests_run;
  int                tests_failed;
  string             cur_test;

  gpu_mem_top #(
    .req_depth  (req_depth),
    .resp_depth (resp_depth),
    .mem_words  (mem_words)
  ) uut (
    .clk, .rst,
    .req_valid, .req_write, .req_tag, .req_addr, .req_wdata, .req_credit,
    .resp_valid, .resp_tag, .resp_rdata, .resp_ready
  );

  always #2 clk = ~clk;

  task automatic record_error();
    errors++;
    test_errors++;
  endtask

  task automatic start_test(input string name);
    cur_test    = name;
    test_errors = 0;
  endtask

  task automatic end_test();
    tests_run++;
    if (test_errors == 0) begin
      $display("test %s: pass", cur_test);
    end else begin
      $display("test %s: fail with %0d errors", cur_test, test_errors);
      tests_failed++;
    end
  endtask

  // Called in a cycle where the response head transfers at the next rising edge.
  task automatic check_resp();
    logic [tag_w-1:0]  et;
    logic [data_w-1:0] ed;
    assert (exp_tag.size() > 0) else begin
      $display("%s: a response came out with no request waiting for one", cur_test);
      record_error();
    end
    if (exp_tag.size() > 0) begin
      et = exp_tag.pop_front();
      ed = exp_data.pop_front();
      assert (resp_tag == et) else begin
        $display("ERROR %s: tag expected %h actual %h", cur_test, et, resp_tag);
        record_error();
      end
      assert (resp_rdata == ed) else begin
        $display("ERROR %s: data for tag %h expected %h actual %h", cur_test, et, ed, resp_rdata);
        record_error();
      end
    end
  endtask

  // Outputs only move on the rising edge, so they are stable here.
  task automatic tick();
    @(negedge clk);
    req_valid  = 1'b0;
    resp_ready = ready_level;
    if (req_credit) begin
      credits++;
      credits_returned++;
    end
    assert (credits <= req_depth) else begin
      $display("%s: the LSU holds more credits than the request queue depth", cur_test);
      record_error();
    end
    if (resp_valid && resp_ready) check_resp();
  endtask

  task automatic send(input logic wr, input logic [tag_w-1:0] tag,
                      input logic [addr_w-1:0] addr, input logic [data_w-1:0] data);
    logic [idx_w-1:0] w;
    w = addr[idx_w+1:2];   // Word index wraps at the memory size.
    assert (credits > 0) else begin
      $display("%s: a request was sent without a credit", cur_test);
      record_error();
    end
    req_valid = 1'b1;
    req_write = wr;
    req_tag   = tag;
    req_addr  = addr;
    req_wdata = data;
    credits--;
    sent++;
    exp_tag.push_back(tag);
    if (wr) begin
      ref_mem[w] = data;
      exp_data.push_back('0);
    end else begin
      exp_data.push_back(ref_mem[w]);
    end
  endtask

  task automatic send_random();
    logic              wr;
    logic [tag_w-1:0]  tag;
    logic [addr_w-1:0] addr;
    wr   = 1'($urandom_range(1, 0));
    tag  = tag_w'($urandom_range(127, 0));
    addr = addr_w'($urandom_range(addr_span - 1, 0)) << 2;
    send(wr, tag, addr, $urandom());
  endtask

  task automatic wait_drain(input int limit);
    int n;
    n = 0;
    while ((exp_tag.size() > 0 || credits != req_depth) && n < limit) begin
      tick();
      n++;
    end
    assert (exp_tag.size() == 0 && credits == req_depth) else begin
      $display("%s: timed out waiting for %0d responses and the credits to return",
               cur_test, exp_tag.size());
      record_error();
    end
  endtask

  initial begin
    int n;
    int idle;
    int accepted;
    int stall;
    logic [data_w-1:0] wdata;
    void'($urandom(32'ha8e3));
    clk         = 1'b0;
    rst         = 1'b1;
    req_valid   = 1'b0;
    req_write   = 1'b0;
    req_tag     = '0;
    req_addr    = '0;
    req_wdata   = '0;
    resp_ready  = 1'b0;
    ready_level = 1'b1;
    credits_returned = 0;
    sent         = 0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    for (int i = 0; i < mem_words; i++) ref_mem[i] = '0;
    repeat (10) @(negedge clk);
    rst     = 1'b0;
    credits = req_depth;   // The LSU starts with a full set of credits.

    start_test("reset_state");
    repeat (20) begin
      tick();
      assert (!resp_valid && !req_credit) else begin
        $display("%s: resp_valid or req_credit rose with no request sent", cur_test);
        record_error();
      end
    end
    send(1'b0, 7'h11, 32'd800, '0);   // Word 200 is outside the random range.
    wait_drain(200);
    end_test();

    start_test("write_read");
    wdata = $urandom();
    tick();
    send(1'b1, 7'h21, 32'd68, wdata);
    tick();
    send(1'b0, 7'h22, 32'd68, '0);
    wait_drain(200);
    end_test();

    start_test("random_traffic");
    n    = 0;
    idle = 0;
    while (n < 300 && idle < 200) begin
      tick();
      ready_level = ($urandom_range(3, 0) != 0);
      if (credits > 0 && $urandom_range(3, 0) != 0) begin
        send_random();
        n++;
        idle = 0;
      end else if (credits == 0) begin
        idle++;
      end
    end
    assert (n == 300) else begin
      $display("%s: traffic stalled because no credit came back", cur_test);
      record_error();
    end
    ready_level = 1'b1;
    wait_drain(2000);
    end_test();

    start_test("credit_accounting");
    assert (credits_returned == sent) else begin
      $display("ERROR %s: credits returned expected %0d actual %0d",
               cur_test, sent, credits_returned);
      record_error();
    end
    assert (credits == req_depth) else begin
      $display("ERROR %s: credits held expected %0d actual %0d", cur_test, req_depth, credits);
      record_error();
    end
    end_test();

    start_test("back_pressure");
    ready_level = 1'b0;
    accepted    = 0;
    stall       = 0;
    n           = 0;
    while (stall < 40 && n < 1000) begin   // Forty quiet cycles mean the credits have stopped.
      tick();
      n++;
      if (credits > 0) begin
        send_random();
        accepted++;
        stall = 0;
      end else begin
        stall++;
      end
    end
    assert (n < 1000) else begin
      $display("%s: credits kept returning while responses were held back", cur_test);
      record_error();
    end
    assert (accepted <= req_depth + resp_depth + 1) else begin
      $display("ERROR %s: accepted requests expected at most %0d actual %0d",
               cur_test, req_depth + resp_depth + 1, accepted);
      record_error();
    end
    assert (resp_valid) else begin
      $display("%s: no response was waiting while resp_ready was low", cur_test);
      record_error();
    end
    ready_level = 1'b1;
    wait_drain(1000);
    end_test();

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

/* files.f */
src/gpu_mem_pkg.sv
src/sync_fifo.sv
src/lsu_mem_port.sv
src/mem_bridge_fsm.sv
src/host_mem_agent.sv
src/gpu_mem_top.sv
bench/gpu_mem_tb.sv

/* src/gpu_mem_pkg.sv */
package gpu_mem_pkg;

  localparam int addr_w = 32;
  localparam int data_w = 32;
  localparam int tag_w  = 7;

  // Bridge states. The current state is driven onto the host bus as the op code.
  typedef enum logic [3:0] {
    mb_idle        = 4'd0,
    mb_wr_ack_wait = 4'd1,
    mb_wr_rdy_wait = 4'd2,
    mb_wr_lsu_to   = 4'd3,
    mb_rd_ack_wait = 4'd4,
    mb_rd_rdy_wait = 4'd5,
    mb_rd_lsu_to   = 4'd6
  } mb_op_t;

  typedef struct packed {
    logic              write;
    logic [tag_w-1:0]  tag;
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] wdata;
  } mem_req_t;

  // Write responses carry zero data.
  typedef struct packed {
    logic [tag_w-1:0]  tag;
    logic [data_w-1:0] rdata;
  } mem_resp_t;

endpackage

/* src/gpu_mem_top.sv */
`timescale 1ns/100ps

module gpu_mem_top #(
  parameter int req_depth  = 4,
  parameter int resp_depth = 4,
  parameter int mem_words  = 256,
  parameter int ack_delay  = 2,
  parameter int done_delay = 3
) (
  input  logic                           clk,
  input  logic                           rst,

  input  logic                           req_valid,
  input  logic                           req_write,
  input  logic [gpu_mem_pkg::tag_w-1:0]  req_tag,
  input  logic [gpu_mem_pkg::addr_w-1:0] req_addr,
  input  logic [gpu_mem_pkg::data_w-1:0] req_wdata,
  output logic                           req_credit,

  output logic                           resp_valid,
  output logic [gpu_mem_pkg::tag_w-1:0]  resp_tag,
  output logic [gpu_mem_pkg::data_w-1:0] resp_rdata,
  input  logic                           resp_ready
);

  import gpu_mem_pkg::*;

  logic              mem_wr_en;
  logic              mem_rd_en;
  logic [addr_w-1:0] mem_addr;
  logic [data_w-1:0] mem_wr_data;
  logic [tag_w-1:0]  mem_tag_req;
  logic              mem_ack;
  logic [tag_w-1:0]  mem_tag_resp;
  logic [data_w-1:0] mem_rd_data;

  mb_op_t            mb_op;
  logic [addr_w-1:0] mb_addr;
  logic [data_w-1:0] mb_data_out;
  logic [data_w-1:0] mb_data_in;
  logic              mb_data_we;
  logic              mb_ack;
  logic              mb_done;

  lsu_mem_port #(
    .req_depth  (req_depth),
    .resp_depth (resp_depth)
  ) port (
    .clk, .rst,
    .req_valid, .req_write, .req_tag, .req_addr, .req_wdata, .req_credit,
    .resp_valid, .resp_tag, .resp_rdata, .resp_ready,
    .mem_wr_en, .mem_rd_en, .mem_addr, .mem_wr_data, .mem_tag_req,
    .mem_ack, .mem_tag_resp, .mem_rd_data
  );

  mem_bridge_fsm bridge (
    .clk, .rst,
    .mem_wr_en, .mem_rd_en, .mem_addr, .mem_wr_data, .mem_tag_req,
    .mb_data_in, .mb_data_we, .mb_ack, .mb_done,
    .mem_tag_resp, .mem_rd_data, .mem_ack,
    .mb_op, .mb_data_out, .mb_addr
  );

  host_mem_agent #(
    .mem_words  (mem_words),
    .ack_delay  (ack_delay),
    .done_delay (done_delay)
  ) agent (
    .clk, .rst,
    .mb_op, .mb_addr, .mb_data_out,
    .mb_ack, .mb_done, .mb_data_we, .mb_data_in
  );

endmodule

/* src/host_mem_agent.sv */
`timescale 1ns/100ps

module host_mem_agent #(
  parameter int mem_words  = 256,
  parameter int ack_delay  = 2,   // At least 1.
  parameter int done_delay = 3    // At least 2, so read data leads done.
) (
  input  logic                           clk,
  input  logic                           rst,
  input  gpu_mem_pkg::mb_op_t            mb_op,
  input  logic [gpu_mem_pkg::addr_w-1:0] mb_addr,
  input  logic [gpu_mem_pkg::data_w-1:0] mb_data_out,
  output logic                           mb_ack,
  output logic                           mb_done,
  output logic                           mb_data_we,
  output logic [gpu_mem_pkg::data_w-1:0] mb_data_in
);

  import gpu_mem_pkg::*;

  localparam int idx_w     = (mem_words > 1) ? $clog2(mem_words) : 1;
  localparam int max_delay = (ack_delay > done_delay) ? ack_delay : done_delay;
  localparam int cnt_w     = $clog2(max_delay + 1);

  logic [data_w-1:0] mem [mem_words];
  logic [idx_w-1:0]  word_sel;
  logic [cnt_w-1:0]  cnt;
  logic              ack_phase;
  logic              done_phase;
  logic              wr_op;
  logic              rd_op;
  logic              access;

  initial begin
    for (int i = 0; i < mem_words; i++) begin
      mem[i] = '0;
    end
  end

  // Word addressed, wrapping at the memory size.
  assign word_sel = idx_w'((mb_addr >> 2) % addr_w'(mem_words));

  assign ack_phase  = (mb_op == mb_wr_ack_wait) || (mb_op == mb_rd_ack_wait);
  assign wr_op      = (mb_op == mb_wr_rdy_wait);
  assign rd_op      = (mb_op == mb_rd_rdy_wait);
  assign done_phase = wr_op || rd_op;
  assign access     = done_phase && !mb_done && (cnt == '0);   // First cycle of the done window.

  always_ff @(posedge clk) begin
    if (rst) begin
      mb_ack     <= 1'b0;
      mb_done    <= 1'b0;
      mb_data_we <= 1'b0;
      cnt        <= '0;
    end else begin
      mb_data_we <= 1'b0;
      if (mb_op == mb_idle) begin
        mb_ack  <= 1'b0;   // Handshake lines stay up until the bridge is back in idle.
        mb_done <= 1'b0;
        cnt     <= '0;
      end else if (ack_phase && !mb_ack) begin
        if (cnt == cnt_w'(ack_delay - 1)) begin
          mb_ack <= 1'b1;
          cnt    <= '0;
        end else begin
          cnt <= cnt + 1'b1;
        end
      end else if (done_phase && !mb_done) begin
        if (cnt == cnt_w'(done_delay - 1)) begin
          mb_done <= 1'b1;
          cnt     <= '0;
        end else begin
          cnt <= cnt + 1'b1;
          if (rd_op && cnt == cnt_w'(done_delay - 2)) mb_data_we <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (access && wr_op) begin
      mem[word_sel] <= mb_data_out;
    end
    if (access && rd_op) begin
      mb_data_in <= mem[word_sel];
    end
  end

endmodule

/* src/lsu_mem_port.sv */
`timescale 1ns/100ps

module lsu_mem_port #(
  parameter int req_depth  = 4,
  parameter int resp_depth = 4
) (
  input  logic                           clk,
  input  logic                           rst,

  input  logic                           req_valid,
  input  logic                           req_write,
  input  logic [gpu_mem_pkg::tag_w-1:0]  req_tag,
  input  logic [gpu_mem_pkg::addr_w-1:0] req_addr,
  input  logic [gpu_mem_pkg::data_w-1:0] req_wdata,
  output logic                           req_credit,

  output logic                           resp_valid,
  output logic [gpu_mem_pkg::tag_w-1:0]  resp_tag,
  output logic [gpu_mem_pkg::data_w-1:0] resp_rdata,
  input  logic                           resp_ready,

  output logic                           mem_wr_en,
  output logic                           mem_rd_en,
  output logic [gpu_mem_pkg::addr_w-1:0] mem_addr,
  output logic [gpu_mem_pkg::data_w-1:0] mem_wr_data,
  output logic [gpu_mem_pkg::tag_w-1:0]  mem_tag_req,
  input  logic                           mem_ack,
  input  logic [gpu_mem_pkg::tag_w-1:0]  mem_tag_resp,
  input  logic [gpu_mem_pkg::data_w-1:0] mem_rd_data
);

  import gpu_mem_pkg::*;

  mem_req_t  req_in;
  mem_req_t  req_head;
  mem_resp_t resp_in;
  mem_resp_t resp_head;
  logic      req_empty;
  logic      resp_empty;
  logic      resp_full;
  logic      resp_pop;
  logic      issue;
  logic      outstanding;
  logic      out_write;

  // The LSU only sends with a credit in hand, so the queue always has room.
  assign req_in = '{write: req_write, tag: req_tag, addr: req_addr, wdata: req_wdata};

  sync_fifo #(
    .payload_t (mem_req_t),
    .depth     (req_depth)
  ) req_fifo (
    .clk       (clk),
    .rst       (rst),
    .push      (req_valid),
    .push_data (req_in),
    .pop       (issue),
    .pop_data  (req_head),
    .empty     (req_empty),
    .full      ()
  );

  // With a single access in flight, a non-full queue always has space for its response.
  assign issue       = !outstanding && !req_empty && !resp_full;
  assign mem_wr_en   = issue && req_head.write;
  assign mem_rd_en   = issue && !req_head.write;
  assign mem_addr    = req_head.addr;
  assign mem_wr_data = req_head.wdata;
  assign mem_tag_req = req_head.tag;

  always_ff @(posedge clk) begin
    if (rst) begin
      outstanding <= 1'b0;
      req_credit  <= 1'b0;
    end else begin
      req_credit <= issue;   // One credit back per request leaving the queue.
      if (issue) begin
        outstanding <= 1'b1;
      end else if (mem_ack) begin
        outstanding <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (issue) out_write <= req_head.write;
  end

  assign resp_in = '{tag: mem_tag_resp, rdata: out_write ? '0 : mem_rd_data};

  sync_fifo #(
    .payload_t (mem_resp_t),
    .depth     (resp_depth)
  ) resp_fifo (
    .clk       (clk),
    .rst       (rst),
    .push      (mem_ack),
    .push_data (resp_in),
    .pop       (resp_pop),
    .pop_data  (resp_head),
    .empty     (resp_empty),
    .full      (resp_full)
  );

  assign resp_valid = !resp_empty;
  assign resp_pop   = resp_valid && resp_ready;
  assign resp_tag   = resp_head.tag;
  assign resp_rdata = resp_head.rdata;

endmodule

/* src/mem_bridge_fsm.sv */
`timescale 1ns/100ps

module mem_bridge_fsm (
  input  logic                           clk,
  input  logic                           rst,

  input  logic                           mem_wr_en,
  input  logic                           mem_rd_en,
  input  logic [gpu_mem_pkg::addr_w-1:0] mem_addr,
  input  logic [gpu_mem_pkg::data_w-1:0] mem_wr_data,
  input  logic [gpu_mem_pkg::tag_w-1:0]  mem_tag_req,

  input  logic [gpu_mem_pkg::data_w-1:0] mb_data_in,
  input  logic                           mb_data_we,
  input  logic                           mb_ack,
  input  logic                           mb_done,

  output logic [gpu_mem_pkg::tag_w-1:0]  mem_tag_resp,
  output logic [gpu_mem_pkg::data_w-1:0] mem_rd_data,
  output logic                           mem_ack,

  output gpu_mem_pkg::mb_op_t            mb_op,
  output logic [gpu_mem_pkg::data_w-1:0] mb_data_out,
  output logic [gpu_mem_pkg::addr_w-1:0] mb_addr
);

  import gpu_mem_pkg::*;

  mb_op_t            state;
  mb_op_t            state_next;
  logic [addr_w-1:0] addr_q;
  logic [data_w-1:0] wdata_q;
  logic [tag_w-1:0]  tag_q;
  logic [data_w-1:0] rdata_q;
  logic              ack_q;
  logic              done_q;
  logic              data_we_q;
  logic              ack_rise;
  logic              done_rise;

  assign mb_op        = state;
  assign mb_addr      = addr_q;
  assign mb_data_out  = wdata_q;
  assign mem_tag_resp = tag_q;
  assign mem_rd_data  = rdata_q;

  assign ack_rise  = mb_ack && !ack_q;
  assign done_rise = mb_done && !done_q;
  assign mem_ack   = (state == mb_wr_lsu_to) || (state == mb_rd_lsu_to);

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= mb_idle;
      ack_q     <= 1'b0;
      done_q    <= 1'b0;
      data_we_q <= 1'b0;
    end else begin
      state     <= state_next;
      ack_q     <= mb_ack;
      done_q    <= mb_done;
      data_we_q <= mb_data_we;
    end
  end

  always_ff @(posedge clk) begin
    if (mem_wr_en) begin
      wdata_q <= mem_wr_data;
    end
    if (mem_wr_en || mem_rd_en) begin
      addr_q <= mem_addr;
      tag_q  <= mem_tag_req;
    end
    // Freeze the word in the cycle after the strobe drops, so it survives until the response.
    if (mb_data_we || !data_we_q) begin
      rdata_q <= mb_data_in;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      mb_idle: begin
        if (mem_wr_en) begin
          state_next = mb_wr_ack_wait;
        end else if (mem_rd_en) begin
          state_next = mb_rd_ack_wait;
        end
      end
      mb_wr_ack_wait: if (ack_rise) state_next = mb_wr_rdy_wait;
      mb_wr_rdy_wait: if (done_rise) state_next = mb_wr_lsu_to;
      mb_wr_lsu_to:   state_next = mb_idle;   // Single-cycle response to the LSU side.
      mb_rd_ack_wait: if (ack_rise) state_next = mb_rd_rdy_wait;
      mb_rd_rdy_wait: if (done_rise) state_next = mb_rd_lsu_to;
      mb_rd_lsu_to:   state_next = mb_idle;
      default:        state_next = mb_idle;
    endcase
  end

endmodule

/* src/sync_fifo.sv */
`timescale 1ns/100ps

module sync_fifo #(
  parameter type payload_t = logic,
  parameter int  depth     = 4
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     push,
  input  payload_t push_data,
  input  logic     pop,
  output payload_t pop_data,
  output logic     empty,
  output logic     full
);

  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_w = $clog2(depth + 1);

  payload_t         slots [depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;
  logic             do_push;
  logic             do_pop;

  function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] p);
    return (p == ptr_w'(depth - 1)) ? '0 : p + 1'b1;
  endfunction

  assign do_push  = push && !full;   // Overflow and underflow are dropped.
  assign do_pop   = pop && !empty;
  assign empty    = (count == '0);
  assign full     = (count == cnt_w'(depth));
  assign pop_data = slots[rd_ptr];   // Head is visible without a read cycle.

  always_ff @(posedge clk) begin
    if (do_push) begin
      slots[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= next_ptr(wr_ptr);
      if (do_pop) rd_ptr <= next_ptr(rd_ptr);
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule
